// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_shim_hw_manager
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN) shim_cases.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
shim_pkg.sv
shim_if.sv
shim_fault_encoder.sv
shim_sequencer.sv
shim_status_reg.sv
shim_hw_manager.sv
tb_shim_hw_manager.sv

// ==== shim_cases.txt ====
# fault(hex: 0 lock 1 sense 2 ext 3 thresh 4 dac 5 adc 6 sys_en off) cfg(hex: 3..0 avg win en sys)
# mask(hex, 00 random) init_dly start_dly code(hex) board(8 = lowest mask bit)
40 0 00 15 4 002 0
00 8 00 15 4 200 0
00 f 00 15 4 200 0
00 4 00 15 4 201 0
00 6 00 15 4 201 0
00 2 00 15 4 202 0
00 1 00 15 4 203 0
00 0 00 9999 4 101 0
00 0 00 30 9999 100 0
01 0 00 5 6 204 0
02 0 10 15 4 300 4
04 0 00 15 4 301 0
08 0 00 15 4 400 8
10 0 81 15 4 600 0
20 0 00 15 4 700 8
3a 0 24 15 4 300 2
2c 0 00 15 4 301 0
38 0 80 12 3 400 7
05 0 00 15 4 204 0
41 0 ff 15 4 002 0
30 0 00 15 4 600 8

// ==== shim_fault_encoder.sv ====
`timescale 1ns/1ps

module shim_fault_encoder (
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  sys_en,
  input  logic                  integ_thresh_avg_oob,
  input  logic                  integ_window_oob,
  input  logic                  integ_en_oob,
  input  logic                  sys_en_oob,
  input  logic                  lock_viol,
  input  logic                  ext_shutdown,
  input  shim_pkg::board_mask_t shutdown_sense,
  input  shim_pkg::board_mask_t over_thresh,
  input  shim_pkg::board_mask_t bad_dac_cmd,
  input  shim_pkg::board_mask_t bad_adc_cmd,
  fault_if.encoder              flt
);
  import shim_pkg::*;

  logic         cfg_fault_d;
  status_code_t cfg_code_d;
  logic         run_fault_d;
  status_code_t run_code_d;
  board_num_t   run_board_d;

  // Pre-start checks, highest priority first
  always_comb begin
    cfg_fault_d = 1'b1;
    cfg_code_d  = OK;
    if (integ_thresh_avg_oob) cfg_code_d = INTEG_THRESH_AVG_OOB;
    else if (integ_window_oob) cfg_code_d = INTEG_WINDOW_OOB;
    else if (integ_en_oob)     cfg_code_d = INTEG_EN_OOB;
    else if (sys_en_oob)       cfg_code_d = SYS_EN_OOB;
    else cfg_fault_d = 1'b0; // Config clean
  end

  // Running faults, board only for per-board sources
  always_comb begin
    run_fault_d = 1'b1;
    run_code_d  = OK;
    run_board_d = '0;
    if (!sys_en) run_code_d = PS_SHUTDOWN; // Disable beats everything
    else if (lock_viol) run_code_d = LOCK_VIOL;
    else if (|shutdown_sense) begin
      run_code_d  = SHUTDOWN_SENSE;
      run_board_d = lowest_board(shutdown_sense);
    end else if (ext_shutdown) run_code_d = EXT_SHUTDOWN;
    else if (|over_thresh) begin
      run_code_d  = OVER_THRESH;
      run_board_d = lowest_board(over_thresh);
    end else if (|bad_dac_cmd) begin
      run_code_d  = BAD_DAC_CMD;
      run_board_d = lowest_board(bad_dac_cmd);
    end else if (|bad_adc_cmd) begin
      run_code_d  = BAD_ADC_CMD;
      run_board_d = lowest_board(bad_adc_cmd);
    end else run_fault_d = 1'b0;
  end

  // One register stage for all fault outputs
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      flt.enable    <= 1'b0;
      flt.cfg_fault <= 1'b0;
      flt.cfg_code  <= OK;
      flt.run_fault <= 1'b1;        // Disabled at reset
      flt.run_code  <= PS_SHUTDOWN;
      flt.run_board <= '0;
    end else begin
      flt.enable    <= sys_en;
      flt.cfg_fault <= cfg_fault_d;
      flt.cfg_code  <= cfg_code_d;
      flt.run_fault <= run_fault_d;
      flt.run_code  <= run_code_d;
      flt.run_board <= run_board_d;
    end
  end

  // Sequencer relies on disable showing up as a run fault
  a_disable_is_fault: assert property (@(posedge clk) disable iff (!aresetn)
    !flt.enable |-> flt.run_fault);

endmodule

// ==== shim_hw_manager.sv ====
`timescale 1ns/1ps

module shim_hw_manager #(
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,  // Force release to reset pulse
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,     // Reset pulse width
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,  // Reset pulse to SPI start
  parameter int unsigned SPI_INIT_WAIT        = 25000000,  // Init check timeout
  parameter int unsigned SPI_START_WAIT       = 250000000  // Start check timeout
) (
  input  logic        clk,
  input  logic        aresetn,
  input  logic        sys_en,
  input  logic        spi_off,
  input  logic        ext_shutdown,
  input  logic        integ_thresh_avg_oob,
  input  logic        integ_window_oob,
  input  logic        integ_en_oob,
  input  logic        sys_en_oob,
  input  logic        lock_viol,
  input  logic [7:0]  shutdown_sense, // Per board
  input  logic [7:0]  over_thresh,
  input  logic [7:0]  bad_dac_cmd,
  input  logic [7:0]  bad_adc_cmd,
  output logic        unlock_cfg,
  output logic        spi_clk_power_n,
  output logic        spi_en,
  output logic        shutdown_sense_en,
  output logic        trig_en,
  output logic        n_shutdown_force,
  output logic        n_shutdown_rst,
  output logic [31:0] status_word,
  output logic        ps_interrupt
);
  import shim_pkg::*;

  fault_if      flt ();
  status_if     st ();
  shim_state_t  state;
  status_word_t status_word_u;

  assign status_word = status_word_u.raw;

  shim_fault_encoder shim_fault_encoder_inst (
    .clk, .aresetn, .sys_en, .integ_thresh_avg_oob, .integ_window_oob, .integ_en_oob,
    .sys_en_oob, .lock_viol, .ext_shutdown, .shutdown_sense, .over_thresh, .bad_dac_cmd,
    .bad_adc_cmd, .flt(flt.encoder)
  );

  shim_sequencer #(
    .SHUTDOWN_FORCE_DELAY(SHUTDOWN_FORCE_DELAY), .SHUTDOWN_RESET_PULSE(SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY(SHUTDOWN_RESET_DELAY), .SPI_INIT_WAIT(SPI_INIT_WAIT),
    .SPI_START_WAIT(SPI_START_WAIT)
  ) shim_sequencer_inst (
    .clk, .aresetn, .flt(flt.sequencer), .spi_off, .unlock_cfg, .spi_clk_power_n, .spi_en,
    .shutdown_sense_en, .trig_en, .n_shutdown_force, .n_shutdown_rst, .state,
    .st(st.sequencer)
  );

  shim_status_reg shim_status_reg_inst (
    .clk, .aresetn, .st(st.status), .state, .status_word(status_word_u), .ps_interrupt
  );

endmodule

// ==== shim_if.sv ====
`timescale 1ns/1ps

// Encoded faults, encoder to sequencer
interface fault_if;
  import shim_pkg::*;

  logic         enable;    // Registered sys_en
  logic         cfg_fault; // Any config value out of bounds
  status_code_t cfg_code;  // Winning config code
  logic         run_fault; // Any running fault, disable included
  status_code_t run_code;  // Winning running code
  board_num_t   run_board; // Board of winning source

  modport encoder   (output enable, cfg_fault, cfg_code, run_fault, run_code, run_board);
  modport sequencer (input  enable, cfg_fault, cfg_code, run_fault, run_code, run_board);
endinterface

// State change events, sequencer to status register
interface status_if;
  import shim_pkg::*;

  logic         halt;  // Leaving for HALTED
  logic         start; // Entering RUNNING
  logic         clear; // HALTED back to IDLE
  status_code_t code;  // Halt code
  board_num_t   board; // Halt board

  modport sequencer (output halt, start, clear, code, board);
  modport status    (input  halt, start, clear, code, board);
endinterface

// ==== shim_pkg.sv ====
package shim_pkg;

  // Fixed design constants
  localparam int N_BOARDS            = 8;  // Amplifier boards
  localparam int SPI_INIT_MIN_CYCLES = 10; // Min wait before spi_off counts
  localparam int TIMER_W             = 32; // Sequencer timer width

  // Sequencer state encoding
  typedef enum logic [3:0] {
    IDLE              = 4'd1,
    CONFIRM_SPI_INIT  = 4'd2,
    RELEASE_SD_F      = 4'd3,
    PULSE_SD_RST      = 4'd4,
    SD_RST_DELAY      = 4'd5,
    CONFIRM_SPI_START = 4'd6,
    RUNNING           = 4'd7,
    HALTED            = 4'd8
  } shim_state_t;

  // Status codes, upper byte groups the source
  typedef enum logic [24:0] {
    OK                   = 25'h001, // Basic system
    PS_SHUTDOWN          = 25'h002,
    SPI_START_TIMEOUT    = 25'h100, // SPI subsystem
    SPI_INIT_TIMEOUT     = 25'h101,
    INTEG_THRESH_AVG_OOB = 25'h200, // Config values and lock
    INTEG_WINDOW_OOB     = 25'h201,
    INTEG_EN_OOB         = 25'h202,
    SYS_EN_OOB           = 25'h203,
    LOCK_VIOL            = 25'h204,
    SHUTDOWN_SENSE       = 25'h300, // Shutdown sources
    EXT_SHUTDOWN         = 25'h301,
    OVER_THRESH          = 25'h400, // Integrator
    BAD_DAC_CMD          = 25'h600, // DAC commands
    BAD_ADC_CMD          = 25'h700  // ADC commands
  } status_code_t;

  typedef logic [2:0]          board_num_t;  // Board index
  typedef logic [N_BOARDS-1:0] board_mask_t; // One bit per board

  // Status word, read raw by software or as fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      board_num_t   board; // Bits 31:29
      status_code_t code;  // Bits 28:4
      shim_state_t  state; // Bits 3:0
    } f;
  } status_word_t;

  // Lowest set bit of a board mask, 0 when empty
  function automatic board_num_t lowest_board(input board_mask_t mask);
    board_num_t idx;
    idx = '0;
    for (int i = N_BOARDS - 1; i >= 0; i--) begin
      if (mask[i]) idx = board_num_t'(i); // Lower bits overwrite higher
    end
    return idx;
  endfunction

endpackage

// ==== shim_sequencer.sv ====
`timescale 1ns/1ps

module shim_sequencer #(
  // Cycle counts, defaults for a 250 MHz clock
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,  // 100 ms
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,     // 100 us
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,  // 100 ms
  parameter int unsigned SPI_INIT_WAIT        = 25000000,  // 100 ms
  parameter int unsigned SPI_START_WAIT       = 250000000  // 1 s
) (
  input  logic                  clk,
  input  logic                  aresetn,
  fault_if.sequencer            flt,
  input  logic                  spi_off,
  output logic                  unlock_cfg,
  output logic                  spi_clk_power_n,
  output logic                  spi_en,
  output logic                  shutdown_sense_en,
  output logic                  trig_en,
  output logic                  n_shutdown_force,
  output logic                  n_shutdown_rst,
  output shim_pkg::shim_state_t state,
  status_if.sequencer           st
);
  import shim_pkg::*;

  shim_state_t        state_nxt;
  logic [TIMER_W-1:0] timer;  // Cycles spent in current timed state
  logic               timed;  // Timer runs in this state

  assign timed = state inside {CONFIRM_SPI_INIT, RELEASE_SD_F, PULSE_SD_RST,
                               SD_RST_DELAY, CONFIRM_SPI_START};

  // Next state and status events
  always_comb begin
    state_nxt = state;
    st.halt   = 1'b0;
    st.start  = 1'b0;
    st.clear  = 1'b0;
    st.code   = OK;
    st.board  = '0;  // Only run faults carry a board
    case (state)
      IDLE: begin
        if (flt.enable) begin
          if (flt.cfg_fault) begin // Bad config, never power up
            state_nxt = HALTED;
            st.halt   = 1'b1;
            st.code   = flt.cfg_code;
          end else state_nxt = CONFIRM_SPI_INIT;
        end
      end
      CONFIRM_SPI_INIT: begin
        if (timer >= TIMER_W'(SPI_INIT_MIN_CYCLES) && spi_off) state_nxt = RELEASE_SD_F;
        else if (timer >= TIMER_W'(SPI_INIT_WAIT)) begin
          state_nxt = HALTED; // SPI never reported off
          st.halt   = 1'b1;
          st.code   = SPI_INIT_TIMEOUT;
        end
      end
      RELEASE_SD_F: if (timer >= TIMER_W'(SHUTDOWN_FORCE_DELAY)) state_nxt = PULSE_SD_RST;
      PULSE_SD_RST: if (timer >= TIMER_W'(SHUTDOWN_RESET_PULSE)) state_nxt = SD_RST_DELAY;
      SD_RST_DELAY: if (timer >= TIMER_W'(SHUTDOWN_RESET_DELAY)) state_nxt = CONFIRM_SPI_START;
      CONFIRM_SPI_START: begin
        if (!spi_off) begin // SPI came up
          state_nxt = RUNNING;
          st.start  = 1'b1;
        end else if (timer >= TIMER_W'(SPI_START_WAIT)) begin
          state_nxt = HALTED;
          st.halt   = 1'b1;
          st.code   = SPI_START_TIMEOUT;
        end
      end
      RUNNING: begin
        if (flt.run_fault) begin
          state_nxt = HALTED;
          st.halt   = 1'b1;
          st.code   = flt.run_code;
          st.board  = flt.run_board;
        end
      end
      HALTED: begin
        if (!flt.enable) begin // Wait for software to drop enable
          state_nxt = IDLE;
          st.clear  = 1'b1;
        end
      end
      default: state_nxt = IDLE; // Illegal encodings recover
    endcase
  end

  // State, timer and registered control outputs
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= IDLE;
      timer             <= '0;
      unlock_cfg        <= 1'b1;
      spi_clk_power_n   <= 1'b1;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      trig_en           <= 1'b0;
      n_shutdown_force  <= 1'b0;
      n_shutdown_rst    <= 1'b1;
    end else begin
      state <= state_nxt;
      if (state_nxt != state) timer <= '0; // Restart on every entry
      else if (timed) timer <= timer + 1'b1;
      case (state_nxt)
        IDLE: unlock_cfg <= 1'b1;
        CONFIRM_SPI_INIT: begin
          unlock_cfg      <= 1'b0; // Lock config
          spi_clk_power_n <= 1'b0; // Clock on for init check
        end
        RELEASE_SD_F: begin
          spi_clk_power_n  <= 1'b1;
          n_shutdown_force <= 1'b1;
        end
        PULSE_SD_RST: n_shutdown_rst <= 1'b0;
        SD_RST_DELAY: n_shutdown_rst <= 1'b1;
        CONFIRM_SPI_START: begin
          shutdown_sense_en <= 1'b1;
          spi_clk_power_n   <= 1'b0;
          spi_en            <= 1'b1;
        end
        RUNNING: trig_en <= 1'b1;
        HALTED: begin // Power off, unlock_cfg left as is
          n_shutdown_force  <= 1'b0;
          n_shutdown_rst    <= 1'b1;
          shutdown_sense_en <= 1'b0;
          spi_clk_power_n   <= 1'b1;
          spi_en            <= 1'b0;
          trig_en           <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  a_trig_only_running: assert property (@(posedge clk) disable iff (!aresetn)
    trig_en |-> state == RUNNING);
  a_rst_only_in_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    !n_shutdown_rst |-> state == PULSE_SD_RST);

endmodule

// ==== shim_status_reg.sv ====
`timescale 1ns/1ps

module shim_status_reg (
  input  logic                   clk,
  input  logic                   aresetn,
  status_if.status               st,
  input  shim_pkg::shim_state_t  state,
  output shim_pkg::status_word_t status_word,
  output logic                   ps_interrupt
);
  import shim_pkg::*;

  status_code_t code_q;
  board_num_t   board_q;

  // Latch on the same edge as the sequencer state
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      code_q       <= OK;
      board_q      <= '0;
      ps_interrupt <= 1'b0;
    end else begin
      ps_interrupt <= st.halt | st.start; // One pulse per entry
      if (st.clear) begin
        code_q  <= OK;
        board_q <= '0;
      end else if (st.halt) begin
        code_q  <= st.code;
        board_q <= st.board;
      end
    end
  end

  // Word built field by field
  always_comb begin
    status_word.f.board = board_q;
    status_word.f.code  = code_q;
    status_word.f.state = state; // Live sequencer state
  end

  a_irq_single_cycle: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt);

endmodule

// ==== tb_shim_hw_manager.sv ====
`timescale 1ns/1ps

module tb_shim_hw_manager;
  import shim_pkg::*;

  // Short delays so every phase fits in a quick run
  localparam int unsigned FORCE_DLY  = 20;
  localparam int unsigned RST_PULSE  = 5;
  localparam int unsigned RST_DLY    = 20;
  localparam int unsigned INIT_WAIT  = 200;
  localparam int unsigned START_WAIT = 400;

  logic        clk = 1'b0;
  logic        aresetn = 1'b0;
  logic        sys_en = 1'b0;
  logic        spi_off = 1'b0;
  logic        ext_shutdown = 1'b0;
  logic        integ_thresh_avg_oob = 1'b0;
  logic        integ_window_oob = 1'b0;
  logic        integ_en_oob = 1'b0;
  logic        sys_en_oob = 1'b0;
  logic        lock_viol = 1'b0;
  logic [7:0]  shutdown_sense = 8'h00;
  logic [7:0]  over_thresh = 8'h00;
  logic [7:0]  bad_dac_cmd = 8'h00;
  logic [7:0]  bad_adc_cmd = 8'h00;
  logic        unlock_cfg;
  logic        spi_clk_power_n;
  logic        spi_en;
  logic        shutdown_sense_en;
  logic        trig_en;
  logic        n_shutdown_force;
  logic        n_shutdown_rst;
  logic [31:0] status_word;
  logic        ps_interrupt;
  status_word_t sw;                // Field view of the DUT word

  int          init_dly = 0;       // SPI model delays, per case
  int          start_dly = 0;
  int          init_cnt = 0;
  int          start_cnt = 0;
  logic [31:0] rng = 32'd73994;    // xorshift state

  assign sw = status_word;

  always #5 clk = ~clk;

  shim_hw_manager #(
    .SHUTDOWN_FORCE_DELAY(FORCE_DLY), .SHUTDOWN_RESET_PULSE(RST_PULSE),
    .SHUTDOWN_RESET_DELAY(RST_DLY), .SPI_INIT_WAIT(INIT_WAIT), .SPI_START_WAIT(START_WAIT)
  ) shim_hw_manager_inst (.*);

  // SPI subsystem model
  always @(posedge clk) begin
    if (!aresetn || unlock_cfg) begin // Idle or halted before power-up
      spi_off   <= 1'b0;
      init_cnt  <= 0;
      start_cnt <= 0;
    end else begin
      if (!spi_clk_power_n && !spi_en) begin // Init check, clock on
        init_cnt <= init_cnt + 1;
        if (init_cnt + 1 == init_dly) spi_off <= 1'b1;
      end
      if (spi_en) begin
        start_cnt <= start_cnt + 1;
        if (start_cnt + 1 == start_dly) spi_off <= 1'b0; // Subsystem running
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Index of the first set board, counting up from board 0
  function automatic board_num_t first_board(input logic [7:0] m);
    int i;
    i = 0;
    while (i < 7 && !m[i]) i++;
    return board_num_t'(i);
  endfunction

  task automatic stop_on_error;
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input status_word_t got, input status_word_t want,
                            input string name);
    if (got.raw !== want.raw) begin
      $display("mismatch %s: got %h expected %h", name, got.raw, want.raw);
      stop_on_error();
    end
  endtask

  task automatic check_state(input shim_state_t got, input shim_state_t want,
                             input string name);
    if (got !== want) begin
      $display("mismatch %s: got %h expected %h", name, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string name);
    if (got !== want) begin
      $display("mismatch %s: got %h expected %h", name, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_count(input int got, input int want, input string name);
    if (got != want) begin
      $display("mismatch %s: got %h expected %h", name, got, want);
      stop_on_error();
    end
  endtask

  // All power outputs at their off levels
  task automatic check_power_off;
    check_bit(n_shutdown_force, 1'b0, "n_shutdown_force");
    check_bit(n_shutdown_rst, 1'b1, "n_shutdown_rst");
    check_bit(shutdown_sense_en, 1'b0, "shutdown_sense_en");
    check_bit(spi_clk_power_n, 1'b1, "spi_clk_power_n");
    check_bit(spi_en, 1'b0, "spi_en");
    check_bit(trig_en, 1'b0, "trig_en");
  endtask

  // Sample on falling edges until the state shows up
  task automatic wait_state(input shim_state_t target, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        $display("timeout: state %s not reached within %0d cycles", target.name(), limit);
        stop_on_error();
      end
    end while (sw.f.state !== target);
  endtask

  // Power sequence up to the SPI start check, outputs in order
  task automatic walk_power_up;
    int width;
    wait_state(CONFIRM_SPI_INIT, 10);
    check_bit(unlock_cfg, 1'b0, "unlock_cfg");
    check_bit(spi_clk_power_n, 1'b0, "spi_clk_power_n"); // Clock running
    wait_state(RELEASE_SD_F, INIT_WAIT + 10);
    check_bit(spi_clk_power_n, 1'b1, "spi_clk_power_n");
    check_bit(n_shutdown_force, 1'b1, "n_shutdown_force");
    wait_state(PULSE_SD_RST, FORCE_DLY + 10);
    width = 0;
    while (n_shutdown_rst === 1'b0) begin // Count low cycles
      width++;
      @(negedge clk);
      if (width > RST_PULSE + 10) begin
        $display("timeout: n_shutdown_rst stuck low");
        stop_on_error();
      end
    end
    check_count(width, RST_PULSE + 1, "n_shutdown_rst low cycles");
    wait_state(CONFIRM_SPI_START, RST_DLY + 10);
    check_bit(shutdown_sense_en, 1'b1, "shutdown_sense_en");
    check_bit(spi_en, 1'b1, "spi_en");
    check_bit(spi_clk_power_n, 1'b0, "spi_clk_power_n");
  endtask

  task automatic run_case(input logic [7:0] fault, input logic [3:0] cfg,
                          input logic [7:0] mask, input logic [24:0] code,
                          input logic [3:0] board);
    status_word_t want;
    logic [7:0]   m;
    m = mask;
    while (m == 8'h00) begin // Open mask, pick boards at random
      rng = xorshift(rng);
      m   = rng[7:0];
    end
    want.f.board = (board == 4'h8) ? first_board(m) : board_num_t'(board);
    want.f.code  = status_code_t'(code);
    want.f.state = HALTED;
    @(posedge clk);
    sys_en <= 1'b1;
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} <= cfg;
    if (cfg == 4'h0) begin
      if (want.f.code == SPI_INIT_TIMEOUT) wait_state(CONFIRM_SPI_INIT, 10);
      else walk_power_up();
      if (want.f.code != SPI_INIT_TIMEOUT && want.f.code != SPI_START_TIMEOUT) begin
        wait_state(RUNNING, start_dly + 10);
        check_bit(trig_en, 1'b1, "trig_en");
        check_bit(ps_interrupt, 1'b1, "ps_interrupt");
        @(negedge clk);
        check_bit(ps_interrupt, 1'b0, "ps_interrupt");
        check_state(sw.f.state, RUNNING, "state"); // No fault yet, stays up
        @(posedge clk); // Inject the faults together
        lock_viol      <= fault[0];
        shutdown_sense <= fault[1] ? m : 8'h00;
        ext_shutdown   <= fault[2];
        over_thresh    <= fault[3] ? m : 8'h00;
        bad_dac_cmd    <= fault[4] ? m : 8'h00;
        bad_adc_cmd    <= fault[5] ? m : 8'h00;
        if (fault[6]) sys_en <= 1'b0;
      end
    end
    wait_state(HALTED, START_WAIT + 10);
    check_bit(ps_interrupt, 1'b1, "ps_interrupt");
    check_word(sw, want, "status_word");
    check_bit(unlock_cfg, cfg != 4'h0, "unlock_cfg"); // Config lock untouched by halt
    check_power_off();
    @(negedge clk);
    check_bit(ps_interrupt, 1'b0, "ps_interrupt");
    @(posedge clk); // Clear back to idle
    sys_en <= 1'b0;
    {integ_thresh_avg_oob, integ_window_oob, integ_en_oob, sys_en_oob} <= 4'h0;
    {lock_viol, ext_shutdown} <= 2'b00;
    {shutdown_sense, over_thresh, bad_dac_cmd, bad_adc_cmd} <= 32'h0;
    wait_state(IDLE, 10);
    want.f.board = '0;
    want.f.code  = OK;
    want.f.state = IDLE;
    check_word(sw, want, "status_word");
    check_bit(unlock_cfg, 1'b1, "unlock_cfg");
  endtask

  initial begin
    int           fd;
    int           n;
    int           ncase;
    string        line;
    status_word_t idle_word;
    logic [7:0]   fault;
    logic [3:0]   cfg;
    logic [7:0]   mask;
    logic [24:0]  code;
    logic [3:0]   board;
    repeat (10) @(posedge clk);
    aresetn <= 1'b1;
    @(negedge clk);
    idle_word.f.board = '0;
    idle_word.f.code  = OK;
    idle_word.f.state = IDLE;
    check_word(sw, idle_word, "status_word");
    check_bit(unlock_cfg, 1'b1, "unlock_cfg");
    check_bit(ps_interrupt, 1'b0, "ps_interrupt");
    check_power_off();
    fd = $fopen("shim_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open shim_cases.txt");
      stop_on_error();
    end
    ncase = 0;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line.getc(0) == "#") continue; // Column notes
      n = $sscanf(line, "%h %h %h %d %d %h %h", fault, cfg, mask, init_dly, start_dly,
                  code, board);
      if (n != 7) continue;
      run_case(fault, cfg, mask, code, board);
      ncase++;
    end
    $fclose(fd);
    if (ncase == 0) begin
      $display("no test cases found in shim_cases.txt");
      stop_on_error();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule
